//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_id_stage
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- branch_unit.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module branch_unit
    import isa_pkg::*;
(
    input  logic             valid_i,
    input  logic [`XLEN-1:0] pc_i,
    input  inst_word_u       inst_i,
    input  logic [`XLEN-1:0] rdata1_i,
    input  logic [`XLEN-1:0] rdata2_i,
    output logic             br_taken_o,
    output logic [`XLEN-1:0] br_target_o
);

    logic [`XLEN-1:0] br_dest;
    logic [`XLEN-1:0] jump_dest;
    logic             rs_eq_rt;
    logic             rs_neg;
    logic             rs_zero;
    logic             taken;
    logic [`XLEN-1:0] target;

    assign br_dest   = pc_i + `XLEN'd4
                     + {{(`XLEN-18){inst_i.i.imm[15]}}, inst_i.i.imm, 2'b00};
    assign jump_dest = {pc_i[`XLEN-1:28], inst_i.j.index, 2'b00};
    assign rs_eq_rt  = rdata1_i == rdata2_i;
    assign rs_neg    = rdata1_i[`XLEN-1];
    assign rs_zero   = rdata1_i == '0;

    always_comb begin
        taken  = 1'b0;
        target = br_dest;
        case (inst_i.r.opcode)
            OP_BEQ:  taken = rs_eq_rt;
            OP_BNE:  taken = !rs_eq_rt;
            OP_BLEZ: taken = inst_i.i.rt == '0 && (rs_neg || rs_zero);
            OP_BGTZ: taken = inst_i.i.rt == '0 && !rs_neg && !rs_zero;
            OP_REGIMM: begin
                case (inst_i.i.rt)
                    RI_BLTZ, RI_BLTZAL: taken = rs_neg;
                    RI_BGEZ, RI_BGEZAL: taken = !rs_neg;
                    default:            taken = 1'b0;
                endcase
            end
            OP_J, OP_JAL: begin
                taken  = 1'b1;
                target = jump_dest;
            end
            OP_SPECIAL: begin
                // register jumps, same field qualifiers as the decoder
                target = rdata1_i;
                if (inst_i.r.funct == F_JR) begin
                    taken = inst_i.r.rt == '0 && inst_i.r.rd == '0 && inst_i.r.sa == '0;
                end else if (inst_i.r.funct == F_JALR) begin
                    taken = inst_i.r.rt == '0 && inst_i.r.sa == '0;
                end
            end
            default: taken = 1'b0;
        endcase

        br_taken_o  = valid_i && taken;
        br_target_o = br_taken_o ? target : '0;

        // an empty slot carries the zero word, which never branches
        taken_needs_valid: assert (!taken || valid_i);
    end

endmodule

//--- ctrl_pkg.sv
package ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_NONE = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_AND  = 4'd5,
        ALU_NOR  = 4'd6,
        ALU_OR   = 4'd7,
        ALU_XOR  = 4'd8,
        ALU_SLL  = 4'd9,
        ALU_SRL  = 4'd10,
        ALU_SRA  = 4'd11,
        ALU_LUI  = 4'd12
    } alu_op_e;

    // first alu operand
    typedef enum logic [1:0] {
        SRC1_RS = 2'd0,
        SRC1_PC = 2'd1,
        SRC1_SA = 2'd2
    } src1_sel_e;

    // second alu operand
    typedef enum logic [1:0] {
        SRC2_RT        = 2'd0,
        SRC2_IMM_SEXT  = 2'd1,
        SRC2_EIGHT     = 2'd2,
        SRC2_IMM_ZEXT  = 2'd3
    } src2_sel_e;

endpackage

//--- files.f
+incdir+.
isa_pkg.sv
ctrl_pkg.sv
id_latch.sv
operand_fetch.sv
inst_decode.sv
branch_unit.sv
id_stage.sv
tb_id_stage.sv

//--- id_latch.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module id_latch
    import isa_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             flush_i,
    input  logic             stall_if_i,
    input  logic             stall_id_i,
    input  logic             if_valid_i,
    input  logic [`XLEN-1:0] if_pc_i,
    input  logic [`XLEN-1:0] inst_rdata_i,
    output logic             valid_o,
    output logic [`XLEN-1:0] pc_o,
    output inst_word_u       inst_o
);

    logic             valid_q;
    logic [`XLEN-1:0] pc_q;
    logic             hold_q;
    logic [`XLEN-1:0] buf_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            pc_q    <= '0;
            hold_q  <= 1'b0;
            buf_q   <= '0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
            hold_q  <= 1'b0;
        end else if (stall_if_i && !stall_id_i) begin
            // bubble while fetch waits
            valid_q <= 1'b0;
            hold_q  <= 1'b0;
        end else if (!stall_id_i) begin
            valid_q <= if_valid_i;
            pc_q    <= if_pc_i;
            hold_q  <= 1'b0;
        end else if (stall_if_i && !hold_q && valid_q) begin
            // memory output moves on, keep the first word
            hold_q <= 1'b1;
            buf_q  <= inst_rdata_i;
        end
    end

    assign valid_o = valid_q;
    assign pc_o    = pc_q;
    assign inst_o  = !valid_q ? '0 : (hold_q ? buf_q : inst_rdata_i);

    hold_needs_valid: assert property (
        @(posedge clk) disable iff (rst) hold_q |-> valid_q
    );

endmodule

//--- id_settings.svh
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// data and pc width
`define XLEN 32

// register index width and register count
`define REG_ADDR_W 5
`define REG_COUNT 32

// link destination of jal, bgezal and bltzal
`define LINK_REG 31

`endif

//--- id_stage.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module id_stage
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush_i,
    input  logic                   stall_if_i,
    input  logic                   stall_id_i,
    input  logic                   if_valid_i,
    input  logic [`XLEN-1:0]       if_pc_i,
    input  logic [`XLEN-1:0]       inst_rdata_i,
    input  logic                   ex_we_i,
    input  logic [`REG_ADDR_W-1:0] ex_waddr_i,
    input  logic [`XLEN-1:0]       ex_wdata_i,
    input  logic                   mem_we_i,
    input  logic [`REG_ADDR_W-1:0] mem_waddr_i,
    input  logic [`XLEN-1:0]       mem_wdata_i,
    input  logic                   wb_we_i,
    input  logic [`REG_ADDR_W-1:0] wb_waddr_i,
    input  logic [`XLEN-1:0]       wb_wdata_i,
    output logic [`XLEN-1:0]       pc_o,
    output inst_word_u             inst_o,
    output logic [`XLEN-1:0]       rdata1_o,
    output logic [`XLEN-1:0]       rdata2_o,
    output alu_op_e                alu_op_o,
    output src1_sel_e              src1_sel_o,
    output src2_sel_e              src2_sel_o,
    output logic                   rf_we_o,
    output logic [`REG_ADDR_W-1:0] rf_waddr_o,
    output logic                   br_taken_o,
    output logic [`XLEN-1:0]       br_target_o
);

    logic valid;

    id_latch u_latch (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (flush_i),
        .stall_if_i   (stall_if_i),
        .stall_id_i   (stall_id_i),
        .if_valid_i   (if_valid_i),
        .if_pc_i      (if_pc_i),
        .inst_rdata_i (inst_rdata_i),
        .valid_o      (valid),
        .pc_o         (pc_o),
        .inst_o       (inst_o)
    );

    operand_fetch u_operand_fetch (
        .clk         (clk),
        .inst_i      (inst_o),
        .ex_we_i     (ex_we_i),
        .ex_waddr_i  (ex_waddr_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_we_i    (mem_we_i),
        .mem_waddr_i (mem_waddr_i),
        .mem_wdata_i (mem_wdata_i),
        .wb_we_i     (wb_we_i),
        .wb_waddr_i  (wb_waddr_i),
        .wb_wdata_i  (wb_wdata_i),
        .rdata1_o    (rdata1_o),
        .rdata2_o    (rdata2_o)
    );

    inst_decode u_decode (
        .valid_i    (valid),
        .inst_i     (inst_o),
        .alu_op_o   (alu_op_o),
        .src1_sel_o (src1_sel_o),
        .src2_sel_o (src2_sel_o),
        .rf_we_o    (rf_we_o),
        .rf_waddr_o (rf_waddr_o)
    );

    branch_unit u_branch (
        .valid_i     (valid),
        .pc_i        (pc_o),
        .inst_i      (inst_o),
        .rdata1_i    (rdata1_o),
        .rdata2_i    (rdata2_o),
        .br_taken_o  (br_taken_o),
        .br_target_o (br_target_o)
    );

endmodule

//--- id_stimulus.txt
# in: flush stall_if stall_id if_valid if_pc inst ex_we/addr/data mem_we/addr/data wb_we/addr/data
# out: pc inst rdata1 rdata2 alu_op src1 src2 rf_we rf_waddr br_taken br_target
0 0 0 1 100 0 0 0 0 0 0 0 1 1 a  0 0 0 0 9 2 0 0 0 0 0
0 0 0 1 104 00221820 0 0 0 0 0 0 1 2 5  100 00221820 a 5 1 0 0 1 3 0 0
0 0 0 1 108 00222022 1 1 111 1 1 222 1 2 7  104 00222022 111 7 2 0 0 1 4 0 0
0 0 0 1 10c 00222825 0 0 0 1 1 222 1 1 333  108 00222825 222 7 7 0 0 1 5 0 0
0 0 0 1 110 0001302a 1 0 dead 0 0 0 0 0 0  10c 0001302a 0 333 3 0 0 1 6 0 0
0 0 0 1 114 00023900 0 0 0 0 0 0 0 0 0  110 00023900 0 7 9 2 0 1 7 0 0
0 0 0 1 118 2028ffff 0 0 0 0 0 0 1 8 0  114 2028ffff 333 0 1 0 1 1 8 0 0
0 0 0 1 11c 344900f0 0 0 0 0 0 0 1 9 0  118 344900f0 7 0 7 0 3 1 9 0 0
0 0 0 1 120 3c081234 0 0 0 0 0 0 0 0 0  11c 3c081234 0 0 c 0 1 1 8 0 0
0 0 0 1 124 fc000000 0 0 0 0 0 0 0 0 0  120 fc000000 0 0 0 0 0 0 0 0 0
0 0 0 1 128 10210004 0 0 0 0 0 0 0 0 0  124 10210004 333 333 0 0 0 0 0 1 138
0 0 0 1 12c 1421fffe 0 0 0 0 0 0 0 0 0  128 1421fffe 333 333 0 0 0 0 0 0 0
0 0 0 1 130 05010001 0 0 0 0 0 0 0 0 0  12c 05010001 0 333 0 0 0 0 0 1 134
0 0 0 1 134 04300008 0 0 0 0 0 0 1 10 0  130 04300008 333 0 1 1 2 1 1f 0 0
0 0 0 1 138 04310010 0 0 0 0 0 0 1 11 0  134 04310010 333 0 1 1 2 1 1f 1 178
0 0 0 1 13c 1c40fffc 0 0 0 0 0 0 0 0 0  138 1c40fffc 7 0 0 0 0 0 0 1 12c
0 0 0 1 140 18400004 0 0 0 0 0 0 0 0 0  13c 18400004 7 0 0 0 0 0 0 0 0
0 0 0 1 144 0c000040 0 0 0 0 0 0 0 0 0  140 0c000040 0 0 1 1 2 1 1f 1 100
0 0 0 1 148 00402809 0 0 0 0 0 0 0 0 0  144 00402809 7 0 1 1 2 1 5 1 7
0 0 0 1 14c 00200008 0 0 0 0 0 0 0 0 0  148 00200008 333 0 0 0 0 0 0 1 333
0 0 0 1 150 08000010 0 0 0 0 0 0 0 0 0  14c 08000010 0 0 0 0 0 0 0 1 40
0 1 0 1 154 00221820 0 0 0 0 0 0 0 0 0  150 00221820 333 7 1 0 0 1 3 0 0
0 0 0 1 158 00222022 0 0 0 0 0 0 0 0 0  150 0 0 0 9 2 0 0 0 0 0
0 1 1 1 15c 00222825 0 0 0 0 0 0 0 0 0  158 00222825 333 7 7 0 0 1 5 0 0
0 1 1 1 15c fc000000 0 0 0 0 0 0 0 0 0  158 00222825 333 7 7 0 0 1 5 0 0
0 0 0 1 15c fc000000 0 0 0 0 0 0 0 0 0  158 00222825 333 7 7 0 0 1 5 0 0
1 0 0 1 160 00222022 0 0 0 0 0 0 0 0 0  15c 00222022 333 7 2 0 0 1 4 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  15c 0 0 0 9 2 0 0 0 0 0

//--- inst_decode.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module inst_decode
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic                   valid_i,
    input  inst_word_u             inst_i,
    output alu_op_e                alu_op_o,
    output src1_sel_e              src1_sel_o,
    output src2_sel_e              src2_sel_o,
    output logic                   rf_we_o,
    output logic [`REG_ADDR_W-1:0] rf_waddr_o
);

    alu_op_e                r_op;
    logic                   we;
    logic                   imm_alu;
    logic                   link;
    logic [`REG_ADDR_W-1:0] waddr;

    // operation implied by funct alone
    always_comb begin
        case (inst_i.r.funct)
            F_ADD, F_ADDU:  r_op = ALU_ADD;
            F_SUB, F_SUBU:  r_op = ALU_SUB;
            F_SLT:          r_op = ALU_SLT;
            F_SLTU:         r_op = ALU_SLTU;
            F_AND:          r_op = ALU_AND;
            F_OR:           r_op = ALU_OR;
            F_XOR:          r_op = ALU_XOR;
            F_NOR:          r_op = ALU_NOR;
            F_SLL, F_SLLV:  r_op = ALU_SLL;
            F_SRL, F_SRLV:  r_op = ALU_SRL;
            F_SRA, F_SRAV:  r_op = ALU_SRA;
            default:        r_op = ALU_NONE;
        endcase
    end

    always_comb begin
        alu_op_o   = ALU_NONE;
        src1_sel_o = SRC1_RS;
        src2_sel_o = SRC2_RT;
        we         = 1'b0;
        imm_alu    = 1'b0;
        link       = 1'b0;
        waddr      = '0;
        case (inst_i.r.opcode)
            OP_SPECIAL: begin
                case (inst_i.r.funct)
                    F_SLL, F_SRL, F_SRA: begin
                        if (inst_i.r.rs == '0) begin
                            alu_op_o   = r_op;
                            src1_sel_o = SRC1_SA;
                            we         = 1'b1;
                            waddr      = inst_i.r.rd;
                        end
                    end
                    F_JALR: begin
                        if (inst_i.r.rt == '0 && inst_i.r.sa == '0) begin
                            link  = 1'b1;
                            waddr = inst_i.r.rd;
                        end
                    end
                    default: begin
                        // jr lands here with no alu op
                        if (inst_i.r.sa == '0 && r_op != ALU_NONE) begin
                            alu_op_o = r_op;
                            we       = 1'b1;
                            waddr    = inst_i.r.rd;
                        end
                    end
                endcase
            end
            OP_REGIMM: begin
                if (inst_i.i.rt == RI_BLTZAL || inst_i.i.rt == RI_BGEZAL) begin
                    link  = 1'b1;
                    waddr = `REG_ADDR_W'(`LINK_REG);
                end
            end
            OP_JAL: begin
                link  = 1'b1;
                waddr = `REG_ADDR_W'(`LINK_REG);
            end
            OP_ADDI, OP_ADDIU: begin
                alu_op_o   = ALU_ADD;
                src2_sel_o = SRC2_IMM_SEXT;
                imm_alu    = 1'b1;
            end
            OP_SLTI: begin
                alu_op_o   = ALU_SLT;
                src2_sel_o = SRC2_IMM_SEXT;
                imm_alu    = 1'b1;
            end
            OP_SLTIU: begin
                alu_op_o   = ALU_SLTU;
                src2_sel_o = SRC2_IMM_SEXT;
                imm_alu    = 1'b1;
            end
            OP_ANDI: begin
                alu_op_o   = ALU_AND;
                src2_sel_o = SRC2_IMM_ZEXT;
                imm_alu    = 1'b1;
            end
            OP_ORI: begin
                alu_op_o   = ALU_OR;
                src2_sel_o = SRC2_IMM_ZEXT;
                imm_alu    = 1'b1;
            end
            OP_XORI: begin
                alu_op_o   = ALU_XOR;
                src2_sel_o = SRC2_IMM_ZEXT;
                imm_alu    = 1'b1;
            end
            OP_LUI: begin
                alu_op_o   = ALU_LUI;
                src2_sel_o = SRC2_IMM_SEXT;
                imm_alu    = 1'b1;
            end
            default: ;
        endcase

        if (imm_alu) begin
            we    = 1'b1;
            waddr = inst_i.i.rt;
        end
        // return address is pc + 8
        if (link) begin
            alu_op_o   = ALU_ADD;
            src1_sel_o = SRC1_PC;
            src2_sel_o = SRC2_EIGHT;
            we         = 1'b1;
        end

        rf_we_o    = valid_i && we;
        rf_waddr_o = waddr;

        write_has_op: assert (!rf_we_o || alu_op_o != ALU_NONE);
    end

endmodule

//--- isa_pkg.sv
package isa_pkg;

    // r-type view
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } inst_r_t;

    // i-type view
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } inst_i_t;

    // j-type view
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index;
    } inst_j_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_j_t j;
    } inst_word_u;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SRA  = 6'h03,
        F_SLLV = 6'h04,
        F_SRLV = 6'h06,
        F_SRAV = 6'h07,
        F_JR   = 6'h08,
        F_JALR = 6'h09,
        F_ADD  = 6'h20,
        F_ADDU = 6'h21,
        F_SUB  = 6'h22,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_e;

    // rt field of the regimm opcode
    typedef enum logic [4:0] {
        RI_BLTZ   = 5'h00,
        RI_BGEZ   = 5'h01,
        RI_BLTZAL = 5'h10,
        RI_BGEZAL = 5'h11
    } regimm_e;

endpackage

//--- operand_fetch.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module operand_fetch
    import isa_pkg::*;
(
    input  logic                   clk,
    input  inst_word_u             inst_i,
    input  logic                   ex_we_i,
    input  logic [`REG_ADDR_W-1:0] ex_waddr_i,
    input  logic [`XLEN-1:0]       ex_wdata_i,
    input  logic                   mem_we_i,
    input  logic [`REG_ADDR_W-1:0] mem_waddr_i,
    input  logic [`XLEN-1:0]       mem_wdata_i,
    input  logic                   wb_we_i,
    input  logic [`REG_ADDR_W-1:0] wb_waddr_i,
    input  logic [`XLEN-1:0]       wb_wdata_i,
    output logic [`XLEN-1:0]       rdata1_o,
    output logic [`XLEN-1:0]       rdata2_o
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // writes to r0 store zero
    always_ff @(posedge clk) begin
        if (wb_we_i) begin
            regs[wb_waddr_i] <= (wb_waddr_i == '0) ? '0 : wb_wdata_i;
        end
    end

    // newest producer wins
    function automatic logic [`XLEN-1:0] forward(
        input logic [`REG_ADDR_W-1:0] addr,
        input logic [`XLEN-1:0]       stored
    );
        if (addr == '0) begin
            return '0;
        end
        if (ex_we_i && ex_waddr_i == addr) begin
            return ex_wdata_i;
        end
        if (mem_we_i && mem_waddr_i == addr) begin
            return mem_wdata_i;
        end
        if (wb_we_i && wb_waddr_i == addr) begin
            return wb_wdata_i;
        end
        return stored;
    endfunction

    always_comb begin
        rdata1_o = forward(inst_i.r.rs, regs[inst_i.r.rs]);
        rdata2_o = forward(inst_i.r.rt, regs[inst_i.r.rt]);
    end

    r0_stays_zero: assert property (
        @(posedge clk) (wb_we_i && wb_waddr_i == '0) |=> (regs[0] == '0)
    );

endmodule

//--- tb_id_stage.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module tb_id_stage
    import isa_pkg::*;
    import ctrl_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int MAX_LINES  = 1000;
    localparam int COLS       = 26;

    logic                   clk;
    logic                   rst;
    logic                   flush_i;
    logic                   stall_if_i;
    logic                   stall_id_i;
    logic                   if_valid_i;
    logic [`XLEN-1:0]       if_pc_i;
    logic [`XLEN-1:0]       inst_rdata_i;
    logic                   ex_we_i;
    logic [`REG_ADDR_W-1:0] ex_waddr_i;
    logic [`XLEN-1:0]       ex_wdata_i;
    logic                   mem_we_i;
    logic [`REG_ADDR_W-1:0] mem_waddr_i;
    logic [`XLEN-1:0]       mem_wdata_i;
    logic                   wb_we_i;
    logic [`REG_ADDR_W-1:0] wb_waddr_i;
    logic [`XLEN-1:0]       wb_wdata_i;
    logic [`XLEN-1:0]       pc_o;
    inst_word_u             inst_o;
    logic [`XLEN-1:0]       rdata1_o;
    logic [`XLEN-1:0]       rdata2_o;
    alu_op_e                alu_op_o;
    src1_sel_e              src1_sel_o;
    src2_sel_e              src2_sel_o;
    logic                   rf_we_o;
    logic [`REG_ADDR_W-1:0] rf_waddr_o;
    logic                   br_taken_o;
    logic [`XLEN-1:0]       br_target_o;

    id_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, exp, act);
            stop_run("output differs from the stimulus file");
        end
    endtask

    // watchdog over the whole run
    initial begin
        #(CLK_PERIOD * 5000);
        stop_run("timeout: the run did not finish in time");
    end

    initial begin
        integer     fd;
        integer     n;
        integer     lines;
        string      text;
        logic [31:0] f [COLS];

        rst          = 1'b1;
        flush_i      = 1'b0;
        stall_if_i   = 1'b0;
        stall_id_i   = 1'b0;
        if_valid_i   = 1'b0;
        if_pc_i      = '0;
        inst_rdata_i = '0;
        ex_we_i      = 1'b0;
        ex_waddr_i   = '0;
        ex_wdata_i   = '0;
        mem_we_i     = 1'b0;
        mem_waddr_i  = '0;
        mem_wdata_i  = '0;
        wb_we_i      = 1'b0;
        wb_waddr_i   = '0;
        wb_wdata_i   = '0;

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("id_stimulus.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open id_stimulus.txt");
        end
        lines = 0;
        while (!$feof(fd) && lines < MAX_LINES) begin
            text = "";
            void'($fgets(text, fd));
            lines = lines + 1;
            if (text.len() < 2 || text[0] == "#") begin
                continue;
            end
            n = $sscanf(text,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20],
                f[21], f[22], f[23], f[24], f[25]);
            if (n != COLS) begin
                stop_run($sformatf("stimulus line %0d has %0d fields", lines, n));
            end

            @(posedge clk);
            flush_i      <= f[0][0];
            stall_if_i   <= f[1][0];
            stall_id_i   <= f[2][0];
            if_valid_i   <= f[3][0];
            if_pc_i      <= f[4];
            inst_rdata_i <= f[5];
            ex_we_i      <= f[6][0];
            ex_waddr_i   <= f[7][`REG_ADDR_W-1:0];
            ex_wdata_i   <= f[8];
            mem_we_i     <= f[9][0];
            mem_waddr_i  <= f[10][`REG_ADDR_W-1:0];
            mem_wdata_i  <= f[11];
            wb_we_i      <= f[12][0];
            wb_waddr_i   <= f[13][`REG_ADDR_W-1:0];
            wb_wdata_i   <= f[14];

            // outputs settle well before the next edge
            #10;
            check_value("pc_o", f[15], pc_o);
            check_value("inst_o", f[16], 32'(inst_o));
            check_value("rdata1_o", f[17], rdata1_o);
            check_value("rdata2_o", f[18], rdata2_o);
            check_value("alu_op_o", f[19], 32'(alu_op_o));
            check_value("src1_sel_o", f[20], 32'(src1_sel_o));
            check_value("src2_sel_o", f[21], 32'(src2_sel_o));
            check_value("rf_we_o", f[22], 32'(rf_we_o));
            check_value("rf_waddr_o", f[23], 32'(rf_waddr_o));
            check_value("br_taken_o", f[24], 32'(br_taken_o));
            check_value("br_target_o", f[25], br_target_o);
        end
        if (!$feof(fd)) begin
            stop_run("stimulus file has no end within the line limit");
        end
        $fclose(fd);

        // let the last writes drain
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
        end
        $display("** PASS **");
        $finish;
    end

endmodule
